// ==== build.f ====
+incdir+src
src/vec_pkg.sv
src/vec_cmd_decode.sv
src/vec_iter_ctrl.sv
src/vec_regfile.sv
src/vec_alu.sv
src/vec_unit.sv
sim/tb_vec_unit.sv

// ==== sim/tb_vec_unit.sv ====
`include "vec_defines.svh"

module tb_vec_unit
    import vec_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // about 30 commands, each up to 64 elements plus stalls plus a 64 entry readback
    localparam int MAX_CYCLES = 10000;

    logic                    clk;
    logic                    rst;
    vec_cmd_t                cmd;
    logic                    cmd_valid;
    logic                    stall;
    logic                    ld_en;
    logic [`VEC_ADDR_W-1:0]  ld_addr;
    logic [`VEC_DATA_W-1:0]  ld_data;
    logic [`VEC_ADDR_W-1:0]  obs_addr;
    logic [`VEC_DATA_W-1:0]  obs_data;
    logic                    done;
    logic                    busy;

    // reference register file, updated in element order
    logic [`VEC_DATA_W-1:0]  model [`VEC_DEPTH];
    logic [`VEC_DATA_W-1:0]  exp_obs;
    logic                    obs_chk;
    logic [31:0]             lcg_state;
    int                      cur_len;
    int                      cycle_cnt;

    // sweep monitor
    logic                    start_cyc;
    logic                    sweep_on;
    int                      free_cycles;
    int                      done_seen;

    vec_unit u_vec_unit (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .stall(stall),
        .ld_en(ld_en), .ld_addr(ld_addr), .ld_data(ld_data), .obs_addr(obs_addr),
        .obs_data(obs_data), .done(done), .busy(busy)
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, sig, got, exp);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("ERROR t=%0t %s", $time, what);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_draw();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // element rule, add and sub wrap modulo 2^32
    function automatic logic [31:0] alu_ref(input vec_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return '0;
        endcase
    endfunction

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run("timeout, cycle limit reached before the tests ended");
        end
    end

    // start cycle follows acceptance, elements are counted from the cycle after
    always @(posedge clk) begin
        if (rst) begin
            start_cyc   <= 1'b0;
            sweep_on    <= 1'b0;
            free_cycles <= 0;
            done_seen   <= 0;
        end else begin
            start_cyc <= cmd_valid && (cmd.arith.op != OP_SETLEN);
            if (start_cyc) begin
                sweep_on    <= 1'b1;
                free_cycles <= 0;
                done_seen   <= 0;
            end else if (sweep_on) begin
                if (!stall) begin
                    free_cycles <= free_cycles + 1;
                end
                if (done) begin
                    done_seen <= done_seen + 1;
                    sweep_on  <= 1'b0;
                end
            end
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        $fell(rst) |-> (!done && !busy))
        else abort_run("done or busy high right after reset");

    a_done_in_sweep: assert property (@(posedge clk) disable iff (rst)
        done |-> sweep_on)
        else abort_run("done pulsed with no arithmetic command running");

    // busy goes up in the cycle right after the command
    a_busy_on_start: assert property (@(posedge clk) disable iff (rst)
        start_cyc |-> busy)
        else abort_run("busy low in the cycle after an arithmetic command");

    // done lands on the len-th unstalled element, never earlier
    a_done_count: assert property (@(posedge clk) disable iff (rst)
        done |-> (free_cycles + 1 == cur_len))
        else report_mismatch("done element count", $sampled(free_cycles) + 1, cur_len);

    a_done_on_time: assert property (@(posedge clk) disable iff (rst)
        (sweep_on && !stall && free_cycles + 1 == cur_len) |-> done)
        else abort_run("done missing on the last unstalled element");

    // last write lands, then busy drops
    a_busy_tail: assert property (@(posedge clk) disable iff (rst)
        done |-> busy ##1 busy ##1 !busy)
        else abort_run("busy did not fall two cycles after done");

    a_single_done: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> (done_seen == 1))
        else report_mismatch("done pulses", $sampled(done_seen), 1);

    a_readback: assert property (@(posedge clk) disable iff (rst)
        obs_chk |-> (obs_data == exp_obs))
        else report_mismatch("obs_data", $sampled(obs_data), $sampled(exp_obs));

    // all tasks start and end 1 ns after a rising edge
    task automatic send_cmd(input vec_cmd_t c);
        cmd       = c;
        cmd_valid = 1'b1;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic load_random();
        for (int a = 0; a < `VEC_DEPTH; a++) begin
            ld_en    = 1'b1;
            ld_addr  = a[`VEC_ADDR_W-1:0];
            ld_data  = lcg_draw();
            model[a] = ld_data;
            @(posedge clk);
            #1;
        end
        ld_en = 1'b0;
    endtask

    task automatic set_length(input int n);
        vec_cmd_t c;
        c            = '0;
        c.setlen.op  = OP_SETLEN;
        c.setlen.len = n[`VEC_LEN_W-1:0];
        cur_len      = n;
        send_cmd(c);
    endtask

    task automatic run_sweep(input vec_op_e op, input int vd, input int vs1, input int vs2,
                             input bit stall_on);
        vec_cmd_t    c;
        logic [31:0] r;
        c          = '0;
        c.arith.op = op;
        c.arith.vd = vd[`VEC_ADDR_W-1:0];
        c.arith.vs1 = vs1[`VEC_ADDR_W-1:0];
        c.arith.vs2 = vs2[`VEC_ADDR_W-1:0];
        // in order, so overlapping operands see earlier results
        for (int i = 0; i < cur_len; i++) begin
            model[6'(vd + i)] = alu_ref(op, model[6'(vs1 + i)], model[6'(vs2 + i)]);
        end
        send_cmd(c);
        while (busy) begin
            r     = lcg_draw();
            // roughly one stalled cycle in four
            stall = stall_on && (r[31:30] == 2'b00);
            @(posedge clk);
            #1;
        end
        stall = 1'b0;
    endtask

    task automatic check_readback();
        for (int a = 0; a < `VEC_DEPTH; a++) begin
            obs_addr = a[`VEC_ADDR_W-1:0];
            exp_obs  = model[a];
            obs_chk  = 1'b1;
            @(posedge clk);
            #1;
        end
        obs_chk = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        clk       = 1'b0;
        rst       = 1'b1;
        cmd       = '0;
        cmd_valid = 1'b0;
        stall     = 1'b0;
        ld_en     = 1'b0;
        ld_addr   = '0;
        ld_data   = '0;
        obs_addr  = '0;
        exp_obs   = '0;
        obs_chk   = 1'b0;
        cycle_cnt = 0;
        lcg_state = 32'd31;
        // length after reset is one
        cur_len   = 1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // quiet gap, done must stay low here
        repeat (4) @(posedge clk);
        #1;
        load_random();
        run_sweep(OP_ADD, 10, 0, 1, 1'b0);
        check_readback();
        // vd equal to vs1, vs2 wraps past 63
        set_length(64);
        run_sweep(OP_SUB, 5, 5, 63, 1'b1);
        check_readback();
        // vd one above vs2, stored length reused
        run_sweep(OP_AND, 20, 62, 19, 1'b0);
        check_readback();
        set_length(7);
        run_sweep(OP_OR, 60, 61, 63, 1'b1);
        check_readback();
        run_sweep(OP_XOR, 1, 3, 0, 1'b1);
        check_readback();
        // random batches, one length then three commands each
        for (int b = 0; b < 8; b++) begin
            load_random();
            r = lcg_draw();
            set_length(1 + r[31:26]);
            for (int k = 0; k < 3; k++) begin
                r = lcg_draw();
                run_sweep(vec_op_e'(4'(1 + r[11:8] % 5)), r[31:26], r[25:20], r[19:14],
                          r[13]);
                check_readback();
            end
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== src/vec_alu.sv ====
`include "vec_defines.svh"

module vec_alu
    import vec_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  vec_op_e                 op,
    input  logic [`VEC_DATA_W-1:0]  opnd_a,
    input  logic [`VEC_DATA_W-1:0]  opnd_b,
    output logic [`VEC_DATA_W-1:0]  result
);

    logic [`VEC_DATA_W-1:0] alu_d;

    // element op, add and sub wrap modulo 2^32
    always_comb begin
        case (op)
            OP_ADD:  alu_d = opnd_a + opnd_b;
            OP_SUB:  alu_d = opnd_a - opnd_b;
            OP_AND:  alu_d = opnd_a & opnd_b;
            OP_OR:   alu_d = opnd_a | opnd_b;
            OP_XOR:  alu_d = opnd_a ^ opnd_b;
            // setlen never reaches here
            default: alu_d = '0;
        endcase
    end

    // loads every cycle, controller decides which ones get written
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= alu_d;
        end
    end

endmodule

// ==== src/vec_cmd_decode.sv ====
`include "vec_defines.svh"

module vec_cmd_decode
    import vec_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  vec_cmd_t                cmd,
    input  logic                    cmd_valid,
    input  logic                    busy,
    output logic                    len_we,
    output logic [`VEC_LEN_W-1:0]   len,
    output logic                    start,
    output vec_op_e                 op,
    output logic [`VEC_ADDR_W-1:0]  vs1_base,
    output logic [`VEC_ADDR_W-1:0]  vs2_base,
    output logic [`VEC_ADDR_W-1:0]  vd_base
);

    vec_op_e cmd_op;
    logic    is_setlen;
    logic    is_arith;

    // opcode sits in the same bits for both views
    assign cmd_op    = cmd.arith.op;
    assign is_setlen = (cmd_op == OP_SETLEN);

    // unknown opcodes are dropped
    always_comb begin
        case (cmd_op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: is_arith = 1'b1;
            default: is_arith = 1'b0;
        endcase
    end

    // strobes to the controller, one cycle after the command
    always_ff @(posedge clk) begin
        if (rst) begin
            len_we <= 1'b0;
            start  <= 1'b0;
        end else begin
            len_we <= cmd_valid && is_setlen;
            start  <= cmd_valid && is_arith;
        end
    end

    // field capture, held until the next command of that kind
    always_ff @(posedge clk) begin
        if (cmd_valid && is_setlen) begin
            len <= cmd.setlen.len;
        end
        if (cmd_valid && is_arith) begin
            op       <= cmd_op;
            vd_base  <= cmd.arith.vd;
            vs1_base <= cmd.arith.vs1;
            vs2_base <= cmd.arith.vs2;
        end
    end

    // sender must wait for busy to drop, nothing is queued
    a_no_cmd_when_busy: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> !busy)
        else $error("vec_cmd_decode: command issued while busy");

    // zero length would leave the counter with no last element
    a_len_nonzero: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid && is_setlen) |-> (cmd.setlen.len != '0 && cmd.setlen.len <= `VEC_DEPTH))
        else $error("vec_cmd_decode: length out of range");

endmodule

// ==== src/vec_defines.svh ====
`ifndef VEC_DEFINES_SVH
`define VEC_DEFINES_SVH

// element width
`define VEC_DATA_W 32

// register file address, wraps modulo depth
`define VEC_ADDR_W 6
`define VEC_DEPTH 64

// command word and its fields
`define VEC_CMD_W 32
`define VEC_OP_W 4

// length field holds 1..64, so one bit wider than an address
`define VEC_LEN_W 7

`endif

// ==== src/vec_iter_ctrl.sv ====
`include "vec_defines.svh"

module vec_iter_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    len_we,
    input  logic [`VEC_LEN_W-1:0]   len,
    input  logic                    start,
    input  logic                    stall,
    input  logic [`VEC_ADDR_W-1:0]  vs1_base,
    input  logic [`VEC_ADDR_W-1:0]  vs2_base,
    input  logic [`VEC_ADDR_W-1:0]  vd_base,
    output logic [`VEC_ADDR_W-1:0]  rd_addr_a,
    output logic [`VEC_ADDR_W-1:0]  rd_addr_b,
    output logic                    wb_en,
    output logic [`VEC_ADDR_W-1:0]  wb_addr,
    output logic                    done,
    output logic                    busy
);

    localparam logic WAITING  = 1'b0;
    localparam logic COUNTING = 1'b1;

    logic                    state;
    logic                    next_state;
    logic [`VEC_ADDR_W-1:0]  ctr;
    logic [`VEC_ADDR_W-1:0]  len_m1;
    logic [`VEC_LEN_W-1:0]   len_dec;
    logic                    last;
    logic                    rd_valid;
    logic                    wb_valid;

    // stored as length minus one, 64 maps to 63
    assign len_dec = len - 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            len_m1 <= '0;
        end else if (len_we) begin
            len_m1 <= len_dec[`VEC_ADDR_W-1:0];
        end
    end

    assign last = (ctr == len_m1);

    // waiting until start, counting until the last unstalled element
    always_comb begin
        case (state)
            WAITING:  next_state = start ? COUNTING : WAITING;
            COUNTING: next_state = (last && !stall) ? WAITING : COUNTING;
            default:  next_state = WAITING;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WAITING;
        end else begin
            state <= next_state;
        end
    end

    // element index, holds on stall, back to zero after the sweep
    always_ff @(posedge clk) begin
        if (rst) begin
            ctr <= '0;
        end else if (start) begin
            ctr <= '0;
        end else if (state == COUNTING && !stall) begin
            ctr <= last ? '0 : ctr + 1'b1;
        end
    end

    // operand addresses, wrap modulo depth
    assign rd_addr_a = vs1_base + ctr;
    assign rd_addr_b = vs2_base + ctr;

    // a read counts only when not stalled
    assign rd_valid = (state == COUNTING) && !stall;
    assign done     = rd_valid && last;

    // write stage lines up with the alu output register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= vd_base + ctr;
    end

    assign wb_en = wb_valid;

    // covers the decode cycle through the last write
    assign busy = start || (state == COUNTING) || wb_valid;

    // a new sweep may only begin once the previous one has closed
    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> (state == WAITING))
        else $error("vec_iter_ctrl: start during a sweep");

    // a length change mid sweep would let the index run past the end
    a_ctr_in_range: assert property (@(posedge clk) disable iff (rst)
        (state == COUNTING) |-> (ctr <= len_m1))
        else $error("vec_iter_ctrl: element index past length");

endmodule

// ==== src/vec_pkg.sv ====
`include "vec_defines.svh"

package vec_pkg;

    // opcodes, same field position in every command view
    typedef enum logic [`VEC_OP_W-1:0] {
        OP_SETLEN = 4'd0,
        OP_ADD    = 4'd1,
        OP_SUB    = 4'd2,
        OP_AND    = 4'd3,
        OP_OR     = 4'd4,
        OP_XOR    = 4'd5
    } vec_op_e;

    // command word, view picked by the opcode
    typedef union packed {
        // arithmetic view
        struct packed {
            vec_op_e                 op;
            logic [`VEC_ADDR_W-1:0]  vd;
            logic [`VEC_ADDR_W-1:0]  vs1;
            logic [`VEC_ADDR_W-1:0]  vs2;
            // spare low bits
            logic [`VEC_CMD_W-`VEC_OP_W-3*`VEC_ADDR_W-1:0] pad;
        } arith;
        // length view
        struct packed {
            vec_op_e                 op;
            // element count, 1..64
            logic [`VEC_LEN_W-1:0]   len;
            logic [`VEC_CMD_W-`VEC_OP_W-`VEC_LEN_W-1:0] pad;
        } setlen;
    } vec_cmd_t;

endpackage

// ==== src/vec_regfile.sv ====
`include "vec_defines.svh"

module vec_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`VEC_ADDR_W-1:0]  rd_addr_a,
    input  logic [`VEC_ADDR_W-1:0]  rd_addr_b,
    output logic [`VEC_DATA_W-1:0]  opnd_a,
    output logic [`VEC_DATA_W-1:0]  opnd_b,
    input  logic                    wb_en,
    input  logic [`VEC_ADDR_W-1:0]  wb_addr,
    input  logic [`VEC_DATA_W-1:0]  wb_data,
    input  logic                    ld_en,
    input  logic [`VEC_ADDR_W-1:0]  ld_addr,
    input  logic [`VEC_DATA_W-1:0]  ld_data,
    input  logic [`VEC_ADDR_W-1:0]  obs_addr,
    output logic [`VEC_DATA_W-1:0]  obs_data
);

    logic [`VEC_DATA_W-1:0]  mem [`VEC_DEPTH];
    logic                    we;
    logic [`VEC_ADDR_W-1:0]  waddr;
    logic [`VEC_DATA_W-1:0]  wdata;

    // single write port, load outside sweeps, write-back inside
    assign we    = ld_en || wb_en;
    assign waddr = ld_en ? ld_addr : wb_addr;
    assign wdata = ld_en ? ld_data : wb_data;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // previous element is still on the write port when the next one reads,
    // so forward it to keep overlapping operands in order
    assign opnd_a = (we && waddr == rd_addr_a) ? wdata : mem[rd_addr_a];
    assign opnd_b = (we && waddr == rd_addr_b) ? wdata : mem[rd_addr_b];

    // readback sees settled contents only
    assign obs_data = mem[obs_addr];

    // loads are gated by busy outside, write-back only runs while busy
    a_one_writer: assert property (@(posedge clk) disable iff (rst)
        !(ld_en && wb_en))
        else $error("vec_regfile: load collides with write-back");

endmodule

// ==== src/vec_unit.sv ====
`include "vec_defines.svh"

module vec_unit
    import vec_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  vec_cmd_t                cmd,
    input  logic                    cmd_valid,
    input  logic                    stall,
    input  logic                    ld_en,
    input  logic [`VEC_ADDR_W-1:0]  ld_addr,
    input  logic [`VEC_DATA_W-1:0]  ld_data,
    input  logic [`VEC_ADDR_W-1:0]  obs_addr,
    output logic [`VEC_DATA_W-1:0]  obs_data,
    output logic                    done,
    output logic                    busy
);

    // decoder to controller
    logic                    len_we;
    logic [`VEC_LEN_W-1:0]   len;
    logic                    start;
    logic [`VEC_ADDR_W-1:0]  vs1_base;
    logic [`VEC_ADDR_W-1:0]  vs2_base;
    logic [`VEC_ADDR_W-1:0]  vd_base;
    vec_op_e                 op;

    // controller to register file
    logic [`VEC_ADDR_W-1:0]  rd_addr_a;
    logic [`VEC_ADDR_W-1:0]  rd_addr_b;
    logic                    wb_en;
    logic [`VEC_ADDR_W-1:0]  wb_addr;

    // datapath
    logic [`VEC_DATA_W-1:0]  opnd_a;
    logic [`VEC_DATA_W-1:0]  opnd_b;
    logic [`VEC_DATA_W-1:0]  result;

    vec_cmd_decode u_decode (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .busy(busy),
        .len_we(len_we), .len(len), .start(start), .op(op),
        .vs1_base(vs1_base), .vs2_base(vs2_base), .vd_base(vd_base)
    );

    vec_iter_ctrl u_iter_ctrl (
        .clk(clk), .rst(rst), .len_we(len_we), .len(len), .start(start),
        .stall(stall), .vs1_base(vs1_base), .vs2_base(vs2_base), .vd_base(vd_base),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b), .wb_en(wb_en),
        .wb_addr(wb_addr), .done(done), .busy(busy)
    );

    // alu result is the write-back data
    vec_regfile u_regfile (
        .clk(clk), .rst(rst), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .wb_en(wb_en), .wb_addr(wb_addr),
        .wb_data(result), .ld_en(ld_en), .ld_addr(ld_addr), .ld_data(ld_data),
        .obs_addr(obs_addr), .obs_data(obs_data)
    );

    vec_alu u_alu (
        .clk(clk), .rst(rst), .op(op), .opnd_a(opnd_a), .opnd_b(opnd_b),
        .result(result)
    );

endmodule
